// File: design/frame_defs.svh
`ifndef FRAME_DEFS_SVH
`define FRAME_DEFS_SVH

// ==========================================================================
// Frame processor widths and sizes
// ==========================================================================

// Payload and sequence number widths
`define FRAME_DATA_W      256
`define FRAME_PSN_W       24

// Processing lanes and round-robin pointer width
`define FRAME_LANES       4
`define FRAME_LANE_IDX_W  2

// Report FIFO entries
`define RPT_DEPTH         4

// Delay counters and their base offsets
`define DELAY_W           4
// Lane delay is psn[2:0] plus this
`define PROC_BASE_DELAY   2
// Report delay is type plus this
`define RPT_BASE_DELAY    3

`endif

// File: design/frame_pkg.sv
`include "frame_defs.svh"

package frame_pkg;

    // ======================================================================
    // Vector types
    // ======================================================================
    typedef logic [`FRAME_PSN_W-1:0]      psn_t;
    typedef logic [`FRAME_DATA_W-1:0]     fdata_t;
    typedef logic [`DELAY_W-1:0]          delay_t;
    typedef logic [`FRAME_LANE_IDX_W-1:0] lane_idx_t;

    // Frame type on the wire
    typedef enum logic [1:0] {
        FT_HEAD = 2'd0,
        FT_BODY = 2'd1,
        FT_TAIL = 2'd2,
        FT_ERR  = 2'd3
    } frame_type_e;

    // ======================================================================
    // Structs
    // ======================================================================

    // Sideband of every output port, also the report entry
    typedef struct packed {
        psn_t        psn;
        frame_type_e ftype;
    } frame_meta_t;

    // Frame as it moves checker -> lane -> collector
    typedef struct packed {
        frame_meta_t meta;
        fdata_t      data;
        logic        good;
    } frame_t;

    // Lane FSM
    typedef enum logic [1:0] {LANE_IDLE, LANE_WAIT, LANE_DONE} lane_state_e;

    // Report FSM
    typedef enum logic [1:0] {RPT_IDLE, RPT_WAIT, RPT_OUTPUT} rpt_state_e;

endpackage

// File: design/frame_checker.sv
`timescale 1ns/1ns
`include "frame_defs.svh"

module frame_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    // Port 1
    input  logic                        i_valid_1,
    output logic                        o_ready_1,
    input  frame_pkg::frame_type_e      i_frame_type,
    input  frame_pkg::psn_t             i_frame_psn,
    input  frame_pkg::fdata_t           i_frame_data,
    // Lane dispatch
    input  logic [`FRAME_LANES-1:0]     i_lane_free,
    output logic [`FRAME_LANES-1:0]     o_load,
    output frame_pkg::frame_t           o_frame
);

    import frame_pkg::*;

    // Checker state
    psn_t      exp_psn;
    logic      inside_frame;
    lane_idx_t disp_ptr;

    logic      accept;
    logic      seq_ok;
    logic      psn_ok;
    logic      type_ok;
    logic      frame_good;

    // ======================================================================
    // Handshake and frame judgment
    // ======================================================================

    // Ready follows the lane next in line
    assign o_ready_1 = i_lane_free[disp_ptr];
    assign accept    = i_valid_1 && o_ready_1;

    // Head opens a frame, anything else needs one open
    assign seq_ok     = (i_frame_type == FT_HEAD) || inside_frame;
    assign psn_ok     = (i_frame_psn == exp_psn);
    assign type_ok    = (i_frame_type != FT_ERR);
    assign frame_good = seq_ok && psn_ok && type_ok;

    // Shared bus to all lanes, only the strobed one latches
    assign o_frame.meta.psn   = i_frame_psn;
    assign o_frame.meta.ftype = i_frame_type;
    assign o_frame.data       = i_frame_data;
    assign o_frame.good       = frame_good;

    // One-hot load for the pointed lane
    always_comb begin
        o_load = '0;
        if (accept) begin
            o_load[disp_ptr] = 1'b1;
        end
    end

    // ======================================================================
    // Context registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_psn      <= '0;
            inside_frame <= 1'b0;
            disp_ptr     <= '0;
        end else if (accept) begin
            // Expected PSN moves only on good frames
            if (frame_good) begin
                exp_psn <= exp_psn + psn_t'(1);
            end
            // Head/tail context tracks every accepted frame
            if (i_frame_type == FT_HEAD) begin
                inside_frame <= 1'b1;
            end else if (i_frame_type == FT_TAIL) begin
                inside_frame <= 1'b0;
            end
            // Round-robin dispatch
            if (disp_ptr == lane_idx_t'(`FRAME_LANES - 1)) begin
                disp_ptr <= '0;
            end else begin
                disp_ptr <= disp_ptr + lane_idx_t'(1);
            end
        end
    end

endmodule

// File: design/frame_lane.sv
`timescale 1ns/1ns
`include "frame_defs.svh"

module frame_lane (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_load,
    input  frame_pkg::frame_t i_frame,
    input  logic              i_release,
    output logic              o_free,
    output logic              o_done,
    output frame_pkg::frame_t o_frame
);

    import frame_pkg::*;

    lane_state_e state;
    delay_t      delay_cnt;
    frame_t      held;

    // ======================================================================
    // Lane FSM and delay counter
    // ======================================================================

    // Counter loads D and hits 1 on the D-th edge after load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LANE_IDLE;
            delay_cnt <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (i_load) begin
                        delay_cnt <= delay_t'(i_frame.meta.psn[2:0])
                                   + delay_t'(`PROC_BASE_DELAY);
                        state     <= LANE_WAIT;
                    end
                end
                LANE_WAIT: begin
                    delay_cnt <= delay_cnt - delay_t'(1);
                    if (delay_cnt == delay_t'(1)) begin
                        state <= LANE_DONE;
                    end
                end
                LANE_DONE: begin
                    // Held until the collector takes it
                    if (i_release) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // Frame capture, bad frames lose their data here
    always_ff @(posedge clk) begin
        if (i_load && (state == LANE_IDLE)) begin
            held.meta <= i_frame.meta;
            held.good <= i_frame.good;
            held.data <= i_frame.good ? i_frame.data : '0;
        end
    end

    assign o_free  = (state == LANE_IDLE);
    assign o_done  = (state == LANE_DONE);
    assign o_frame = held;

endmodule

// File: design/frame_collector.sv
`timescale 1ns/1ns
`include "frame_defs.svh"

module frame_collector (
    // From lanes
    input  logic [`FRAME_LANES-1:0]  i_lane_done,
    input  frame_pkg::frame_t        i_lane_frame [`FRAME_LANES],
    output logic [`FRAME_LANES-1:0]  o_release,
    // Port 2, good frames
    output logic                     o_valid_2,
    input  logic                     i_ready_2,
    output frame_pkg::psn_t          o_frame_psn_2,
    output frame_pkg::frame_type_e   o_frame_type_2,
    output frame_pkg::fdata_t        o_frame_data_2,
    // Port 3, bad frames
    output logic                     o_valid_3,
    input  logic                     i_ready_3,
    output frame_pkg::psn_t          o_frame_psn_3,
    output frame_pkg::frame_type_e   o_frame_type_3,
    output frame_pkg::fdata_t        o_frame_data_3,
    // Report queue
    output logic                     o_rpt_push,
    output frame_pkg::frame_meta_t   o_rpt_meta,
    input  logic                     i_rpt_full,
    input  logic                     clk,
    input  logic                     rst_n
);

    import frame_pkg::*;

    lane_idx_t drain_ptr;
    frame_t    cur;
    logic      present;
    logic      fire;

    // ======================================================================
    // Output selection
    // ======================================================================

    // Lane under the drain pointer
    assign cur = i_lane_frame[drain_ptr];

    // Presenting also needs room for the report
    assign present = i_lane_done[drain_ptr] && !i_rpt_full;

    assign o_valid_2      = present && cur.good;
    assign o_frame_psn_2  = cur.meta.psn;
    assign o_frame_type_2 = cur.meta.ftype;
    assign o_frame_data_2 = cur.data;

    // Data already zeroed by the lane
    assign o_valid_3      = present && !cur.good;
    assign o_frame_psn_3  = cur.meta.psn;
    assign o_frame_type_3 = cur.meta.ftype;
    assign o_frame_data_3 = cur.data;

    // Transfer on whichever port is live
    assign fire = (o_valid_2 && i_ready_2) || (o_valid_3 && i_ready_3);

    // Report for every completed frame
    assign o_rpt_push = fire;
    assign o_rpt_meta = cur.meta;

    always_comb begin
        o_release = '0;
        if (fire) begin
            o_release[drain_ptr] = 1'b1;
        end
    end

    // ======================================================================
    // Drain pointer
    // ======================================================================

    // Same rotation as dispatch keeps input order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_ptr <= '0;
        end else if (fire) begin
            if (drain_ptr == lane_idx_t'(`FRAME_LANES - 1)) begin
                drain_ptr <= '0;
            end else begin
                drain_ptr <= drain_ptr + lane_idx_t'(1);
            end
        end
    end

endmodule

// File: design/report_queue.sv
`timescale 1ns/1ns
`include "frame_defs.svh"

module report_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    // Push side from collector
    input  logic                    i_push,
    input  frame_pkg::frame_meta_t  i_meta,
    output logic                    o_full,
    // Port 4
    output logic                    o_valid_4,
    input  logic                    i_ready_4,
    output frame_pkg::psn_t         o_frame_psn_4,
    output frame_pkg::frame_type_e  o_frame_type_4
);

    import frame_pkg::*;

    localparam int PTR_W = $clog2(`RPT_DEPTH);

    // FIFO storage and pointers
    frame_meta_t      mem [`RPT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    // Report FSM
    rpt_state_e       state;
    delay_t           wait_cnt;
    frame_meta_t      rpt;

    // ======================================================================
    // Report FIFO
    // ======================================================================
    assign empty   = (count == '0);
    assign o_full  = (count == (PTR_W + 1)'(`RPT_DEPTH));
    assign do_push = i_push && !o_full;
    // Pop straight into the FSM when it is free
    assign do_pop  = (state == RPT_IDLE) && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entries carry no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_meta;
        end
    end

    // ======================================================================
    // Report delay FSM
    // ======================================================================

    // Wait type + base edges after the pop, then hold port 4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RPT_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                RPT_IDLE: begin
                    if (do_pop) begin
                        wait_cnt <= delay_t'(mem[rd_ptr].ftype)
                                  + delay_t'(`RPT_BASE_DELAY);
                        state    <= RPT_WAIT;
                    end
                end
                RPT_WAIT: begin
                    wait_cnt <= wait_cnt - delay_t'(1);
                    if (wait_cnt == delay_t'(1)) begin
                        state <= RPT_OUTPUT;
                    end
                end
                RPT_OUTPUT: begin
                    if (i_ready_4) begin
                        state <= RPT_IDLE;
                    end
                end
                default: state <= RPT_IDLE;
            endcase
        end
    end

    // Head entry captured on pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rpt <= mem[rd_ptr];
        end
    end

    assign o_valid_4      = (state == RPT_OUTPUT);
    assign o_frame_psn_4  = rpt.psn;
    assign o_frame_type_4 = rpt.ftype;

endmodule

// File: design/frame_processor_top.sv
`timescale 1ns/1ns
`include "frame_defs.svh"

module frame_processor_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // Port 1, frame input
    input  logic                    i_valid_1,
    output logic                    o_ready_1,
    input  frame_pkg::frame_type_e  i_frame_type,
    input  frame_pkg::psn_t         i_frame_psn,
    input  frame_pkg::fdata_t       i_frame_data,
    // Port 2, good frames
    output logic                    o_valid_2,
    input  logic                    i_ready_2,
    output frame_pkg::psn_t         o_frame_psn_2,
    output frame_pkg::frame_type_e  o_frame_type_2,
    output frame_pkg::fdata_t       o_frame_data_2,
    // Port 3, bad frames
    output logic                    o_valid_3,
    input  logic                    i_ready_3,
    output frame_pkg::psn_t         o_frame_psn_3,
    output frame_pkg::frame_type_e  o_frame_type_3,
    output frame_pkg::fdata_t       o_frame_data_3,
    // Port 4, reports
    output logic                    o_valid_4,
    input  logic                    i_ready_4,
    output frame_pkg::psn_t         o_frame_psn_4,
    output frame_pkg::frame_type_e  o_frame_type_4
);

    import frame_pkg::*;

    // ======================================================================
    // Internal nets
    // ======================================================================
    logic [`FRAME_LANES-1:0] lane_load;
    logic [`FRAME_LANES-1:0] lane_free;
    logic [`FRAME_LANES-1:0] lane_done;
    logic [`FRAME_LANES-1:0] lane_release;
    frame_t                  chk_frame;
    frame_t                  lane_frame [`FRAME_LANES];
    logic                    rpt_push;
    frame_meta_t             rpt_meta;
    logic                    rpt_full;

    // Judge and dispatch
    frame_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_valid_1    (i_valid_1),
        .o_ready_1    (o_ready_1),
        .i_frame_type (i_frame_type),
        .i_frame_psn  (i_frame_psn),
        .i_frame_data (i_frame_data),
        .i_lane_free  (lane_free),
        .o_load       (lane_load),
        .o_frame      (chk_frame)
    );

    // Processing lanes
    for (genvar gi = 0; gi < `FRAME_LANES; gi++) begin : g_lane
        frame_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .i_load    (lane_load[gi]),
            .i_frame   (chk_frame),
            .i_release (lane_release[gi]),
            .o_free    (lane_free[gi]),
            .o_done    (lane_done[gi]),
            .o_frame   (lane_frame[gi])
        );
    end

    // In-order drain to ports 2 and 3
    frame_collector u_collector (
        .i_lane_done    (lane_done),
        .i_lane_frame   (lane_frame),
        .o_release      (lane_release),
        .o_valid_2      (o_valid_2),
        .i_ready_2      (i_ready_2),
        .o_frame_psn_2  (o_frame_psn_2),
        .o_frame_type_2 (o_frame_type_2),
        .o_frame_data_2 (o_frame_data_2),
        .o_valid_3      (o_valid_3),
        .i_ready_3      (i_ready_3),
        .o_frame_psn_3  (o_frame_psn_3),
        .o_frame_type_3 (o_frame_type_3),
        .o_frame_data_3 (o_frame_data_3),
        .o_rpt_push     (rpt_push),
        .o_rpt_meta     (rpt_meta),
        .i_rpt_full     (rpt_full),
        .clk            (clk),
        .rst_n          (rst_n)
    );

    // Report FIFO and port 4
    report_queue u_report (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_push         (rpt_push),
        .i_meta         (rpt_meta),
        .o_full         (rpt_full),
        .o_valid_4      (o_valid_4),
        .i_ready_4      (i_ready_4),
        .o_frame_psn_4  (o_frame_psn_4),
        .o_frame_type_4 (o_frame_type_4)
    );

endmodule

// File: sim/frame_processor_tb.sv
`timescale 1ns/1ns
`include "frame_defs.svh"

module frame_processor_tb;

    import frame_pkg::*;

    // DUT ports
    logic        clk = 1'b0;
    logic        rst_n;
    logic        i_valid_1;
    logic        o_ready_1;
    frame_type_e i_frame_type;
    psn_t        i_frame_psn;
    fdata_t      i_frame_data;
    logic        o_valid_2;
    logic        i_ready_2;
    psn_t        o_frame_psn_2;
    frame_type_e o_frame_type_2;
    fdata_t      o_frame_data_2;
    logic        o_valid_3;
    logic        i_ready_3;
    psn_t        o_frame_psn_3;
    frame_type_e o_frame_type_3;
    fdata_t      o_frame_data_3;
    logic        o_valid_4;
    logic        i_ready_4;
    psn_t        o_frame_psn_4;
    frame_type_e o_frame_type_4;

    // Reference model and monitor state
    logic [31:0] lfsr_state;
    logic        bp_en;
    psn_t        m_exp_psn;
    logic        m_inside;
    frame_t      exp_out [$];
    frame_meta_t exp_rpt [$];
    int          n_port3;
    logic        stall_2;
    logic        stall_3;
    logic        stall_4;
    logic [511:0] held_2;
    logic [511:0] held_3;
    logic [511:0] held_4;

    frame_processor_top dut (.*);

    // 20 ns clock
    always #10 clk = ~clk;

    // ========================================================================
    // Helpers
    // ========================================================================

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    function automatic fdata_t take_bits(input int n);
        fdata_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[`FRAME_DATA_W-2:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Wait for the falling edge and redraw ready bits under back-pressure
    task automatic step_cycle();
        logic [3:0] b;
        @(negedge clk);
        if (bp_en) begin
            b = 4'(take_bits(4));
            i_ready_2 = b[0];
            i_ready_3 = b[1];
            // Port 4 slower so the report FIFO fills
            i_ready_4 = b[2] & b[3];
        end
    endtask

    // Hold valid until the accepting edge
    task automatic send_frame(input frame_type_e ft, input psn_t psn, input fdata_t data);
        int waited;
        waited       = 0;
        i_valid_1    = 1'b1;
        i_frame_type = ft;
        i_frame_psn  = psn;
        i_frame_data = data;
        while (!o_ready_1) begin
            step_cycle();
            waited++;
            if (waited > 500) begin
                fail_run("Timeout: o_ready_1 stayed low while a frame was waiting");
            end
        end
        step_cycle();
        i_valid_1 = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_out.size() != 0 || exp_rpt.size() != 0) begin
            step_cycle();
            waited++;
            if (waited > 2000) begin
                fail_run("Timeout: expected frames or reports never came out");
            end
        end
    endtask

    // ========================================================================
    // Reference model and output monitors
    // ========================================================================

    // Judge each accepted frame by the three rules
    always @(posedge clk) begin : accept_model
        frame_t f;
        if (rst_n && i_valid_1 && o_ready_1) begin
            f.meta.psn   = i_frame_psn;
            f.meta.ftype = i_frame_type;
            f.good       = (i_frame_type != FT_ERR) && (i_frame_psn == m_exp_psn)
                         && ((i_frame_type == FT_HEAD) || m_inside);
            f.data       = f.good ? i_frame_data : '0;
            exp_out.push_back(f);
            if (f.good) begin
                m_exp_psn = m_exp_psn + psn_t'(1);
            end
            // Context follows heads and tails whether good or not
            if (i_frame_type == FT_HEAD) begin
                m_inside = 1'b1;
            end else if (i_frame_type == FT_TAIL) begin
                m_inside = 1'b0;
            end
        end
    end

    // Each completed output queues its report
    always @(posedge clk) begin : out_monitor
        frame_t f;
        if (rst_n) begin
            if (o_valid_2 && o_valid_3) begin
                fail_run("Ports 2 and 3 were both valid in the same cycle");
            end
            // Stalled payload must hold
            if (stall_2) begin
                check_value("o_valid_2", o_valid_2, 1'b1);
                check_value("port 2 payload", {o_frame_psn_2, o_frame_type_2, o_frame_data_2},
                            held_2);
            end
            if (stall_3) begin
                check_value("o_valid_3", o_valid_3, 1'b1);
                check_value("port 3 payload", {o_frame_psn_3, o_frame_type_3, o_frame_data_3},
                            held_3);
            end
            if (o_valid_2 && i_ready_2) begin
                if (exp_out.size() == 0 || !exp_out[0].good) begin
                    fail_run("Port 2 delivered a frame that was not expected there");
                end
                f = exp_out.pop_front();
                check_value("o_frame_psn_2", o_frame_psn_2, f.meta.psn);
                check_value("o_frame_type_2", o_frame_type_2, f.meta.ftype);
                check_value("o_frame_data_2", o_frame_data_2, f.data);
                exp_rpt.push_back(f.meta);
            end
            if (o_valid_3 && i_ready_3) begin
                if (exp_out.size() == 0 || exp_out[0].good) begin
                    fail_run("Port 3 delivered a frame that was not expected there");
                end
                f = exp_out.pop_front();
                check_value("o_frame_psn_3", o_frame_psn_3, f.meta.psn);
                check_value("o_frame_type_3", o_frame_type_3, f.meta.ftype);
                check_value("o_frame_data_3", o_frame_data_3, f.data);
                exp_rpt.push_back(f.meta);
                n_port3++;
            end
            stall_2 = o_valid_2 && !i_ready_2;
            stall_3 = o_valid_3 && !i_ready_3;
            held_2  = {o_frame_psn_2, o_frame_type_2, o_frame_data_2};
            held_3  = {o_frame_psn_3, o_frame_type_3, o_frame_data_3};
        end
    end

    // Reports in combined output order
    always @(posedge clk) begin : report_monitor
        frame_meta_t m;
        if (rst_n) begin
            if (stall_4) begin
                check_value("o_valid_4", o_valid_4, 1'b1);
                check_value("port 4 payload", {o_frame_psn_4, o_frame_type_4}, held_4);
            end
            if (o_valid_4 && i_ready_4) begin
                if (exp_rpt.size() == 0) begin
                    fail_run("Port 4 delivered a report that was not expected");
                end
                m = exp_rpt.pop_front();
                check_value("o_frame_psn_4", o_frame_psn_4, m.psn);
                check_value("o_frame_type_4", o_frame_type_4, m.ftype);
            end
            stall_4 = o_valid_4 && !i_ready_4;
            held_4  = {o_frame_psn_4, o_frame_type_4};
        end
    end

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic test_reset_state();
        check_value("o_valid_2", o_valid_2, 1'b0);
        check_value("o_valid_3", o_valid_3, 1'b0);
        check_value("o_valid_4", o_valid_4, 1'b0);
        check_value("o_ready_1", o_ready_1, 1'b1);
    endtask

    // Head, bodies, tail all on port 2
    task automatic test_good_sequence();
        psn_t p;
        int   n3;
        p  = m_exp_psn;
        n3 = n_port3;
        send_frame(FT_HEAD, p, take_bits(`FRAME_DATA_W));
        for (int i = 0; i < 6; i++) begin
            p = p + psn_t'(1);
            send_frame(FT_BODY, p, take_bits(`FRAME_DATA_W));
        end
        p = p + psn_t'(1);
        send_frame(FT_TAIL, p, take_bits(`FRAME_DATA_W));
        wait_drain();
        check_value("port 3 frame count", n_port3, n3);
    endtask

    task automatic test_wrong_frames();
        psn_t p;
        int   n3;
        p  = m_exp_psn;
        n3 = n_port3;
        send_frame(FT_HEAD, p, take_bits(`FRAME_DATA_W));
        p = p + psn_t'(1);
        // Error type, then wrong PSN
        send_frame(FT_ERR, p, take_bits(`FRAME_DATA_W));
        send_frame(FT_BODY, p + psn_t'(5), take_bits(`FRAME_DATA_W));
        // Expected PSN did not move
        send_frame(FT_TAIL, p, take_bits(`FRAME_DATA_W));
        p = p + psn_t'(1);
        // Body with no open head
        send_frame(FT_BODY, p, take_bits(`FRAME_DATA_W));
        send_frame(FT_HEAD, p, take_bits(`FRAME_DATA_W));
        p = p + psn_t'(1);
        send_frame(FT_TAIL, p, take_bits(`FRAME_DATA_W));
        wait_drain();
        check_value("port 3 frame count", n_port3, n3 + 3);
    endtask

    // Every type once to cover each report delay
    task automatic test_reports();
        send_frame(FT_HEAD, m_exp_psn, take_bits(`FRAME_DATA_W));
        send_frame(FT_BODY, m_exp_psn, take_bits(`FRAME_DATA_W));
        send_frame(FT_ERR, m_exp_psn, take_bits(`FRAME_DATA_W));
        send_frame(FT_TAIL, m_exp_psn, take_bits(`FRAME_DATA_W));
        wait_drain();
    endtask

    // Long mixed stream under random ready
    task automatic test_back_pressure();
        logic [1:0] ft;
        logic [2:0] sel;
        psn_t       p;
        bp_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            ft  = 2'(take_bits(2));
            sel = 3'(take_bits(3));
            // Roughly one PSN in eight is wrong
            p = (sel == 3'd0) ? m_exp_psn + psn_t'(7) : m_exp_psn;
            send_frame(frame_type_e'(ft), p, take_bits(`FRAME_DATA_W));
            if (2'(take_bits(2)) == 2'd0) begin
                step_cycle();
            end
        end
        bp_en     = 1'b0;
        i_ready_2 = 1'b1;
        i_ready_3 = 1'b1;
        i_ready_4 = 1'b1;
        wait_drain();
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        lfsr_state   = 32'd85090;
        bp_en        = 1'b0;
        m_exp_psn    = '0;
        m_inside     = 1'b0;
        n_port3      = 0;
        stall_2      = 1'b0;
        stall_3      = 1'b0;
        stall_4      = 1'b0;
        rst_n        = 1'b0;
        i_valid_1    = 1'b0;
        i_frame_type = FT_HEAD;
        i_frame_psn  = '0;
        i_frame_data = '0;
        i_ready_2    = 1'b1;
        i_ready_3    = 1'b1;
        i_ready_4    = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_good_sequence();
        test_wrong_frames();
        test_reports();
        test_back_pressure();

        if (exp_out.size() == 0 && exp_rpt.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("Frames or reports were left over at the end of the run");
        end
    end

endmodule

// File: tb.f
+incdir+design
design/frame_pkg.sv
design/frame_checker.sv
design/frame_lane.sv
design/frame_collector.sv
design/report_queue.sv
design/frame_processor_top.sv
sim/frame_processor_tb.sv
